// File: verilog/exec_pkg.sv
// shared widths and uop field map; uop bits 31:24 must be zero and func codes 5 to 7 are unused.
package exec_pkg;

  localparam int WORD_W   = 16;           // data path width.
  localparam int REG_AW   = 3;            // register number width.
  localparam int NUM_REGS = 2 ** REG_AW;  // eight general registers.
  localparam int UOP_W    = 32;
  localparam int FLAG_W   = 4;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [UOP_W-1:0]  uop_t;
  typedef logic [FLAG_W-1:0] flags_t;      // {of, sf, zf, cf}.
  typedef logic [3:0]        cond_t;       // bit 3 inverts the test.
  typedef logic [1:0]        alu_class_t;
  typedef logic [2:0]        alu_func_t;

  // uop field positions, lsb of each field.
  localparam int UOP_ADDR_A = 0;   // 3 bits.
  localparam int UOP_ADDR_B = 3;   // 3 bits.
  localparam int UOP_ADDR_D = 6;   // 3 bits.
  localparam int UOP_B_IMM  = 9;
  localparam int UOP_CLS    = 10;  // 2 bits.
  localparam int UOP_FUNC   = 12;  // 3 bits.
  localparam int UOP_BYTEOP = 15;
  localparam int UOP_WR     = 16;
  localparam int UOP_WRFL   = 17;
  localparam int UOP_WR_CND = 18;
  localparam int UOP_COND   = 19;  // 4 bits.
  localparam int UOP_WE     = 23;

  // alu classes.
  localparam alu_class_t CLS_ARITH = 2'd0;
  localparam alu_class_t CLS_LOGIC = 2'd1;
  localparam alu_class_t CLS_SHIFT = 2'd2;
  localparam alu_class_t CLS_ADDR  = 2'd3;  // a + b, never touches flags.

  // functions per class.
  localparam alu_func_t FN_ADD   = 3'd0;
  localparam alu_func_t FN_ADC   = 3'd1;
  localparam alu_func_t FN_SUB   = 3'd2;
  localparam alu_func_t FN_SBB   = 3'd3;
  localparam alu_func_t FN_PASSB = 3'd4;
  localparam alu_func_t FN_AND   = 3'd0;
  localparam alu_func_t FN_OR    = 3'd1;
  localparam alu_func_t FN_XOR   = 3'd2;
  localparam alu_func_t FN_SHL   = 3'd0;  // shifts move one bit only.
  localparam alu_func_t FN_SHR   = 3'd1;
  localparam alu_func_t FN_SAR   = 3'd2;

  // flag bit positions.
  localparam int FLAG_OF = 3;
  localparam int FLAG_SF = 2;
  localparam int FLAG_ZF = 1;
  localparam int FLAG_CF = 0;

endpackage

// File: verilog/issue_if.sv
// head of the uop queue towards the execution stage; issue may only rise while valid is high.
`timescale 1ns/1ns

interface issue_if;
  import exec_pkg::*;

  logic  valid;  // queue holds an entry.
  uop_t  uop;    // head microinstruction.
  word_t imm;    // its immediate.
  logic  issue;  // stage takes the head, popped on this edge.

  modport queue (
    output valid,
    output uop,
    output imm,
    input  issue
  );

  modport stage (
    input  valid,
    input  uop,
    input  imm,
    output issue
  );

endinterface

// File: verilog/uop_queue.sv
// credit fed uop FIFO; the sender must respect its credits, a push into a full queue is lost.
`timescale 1ns/1ns

module uop_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  exec_pkg::uop_t  in_uop,
  input  exec_pkg::word_t in_imm,
  output logic            credit_ret,
  issue_if.queue          q
);
  import exec_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  uop_t             uop_mem [QUEUE_DEPTH];  // payload only.
  word_t            imm_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // wraps at the depth, not at a power of two.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop     = q.issue;           // stage only issues on valid.
  assign q.valid = (count != '0);
  assign q.uop   = uop_mem[rd_ptr];   // head seen the cycle after its write.
  assign q.imm   = imm_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (in_valid) begin
      uop_mem[wr_ptr] <= in_uop;
      imm_mem[wr_ptr] <= in_imm;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
      credit_ret <= pop;  // slot freed, one cycle late.
    end
  end

endmodule

// File: verilog/regfile.sv
// eight word registers plus flags; reads are combinational, a byte write touches the low lane only.
`timescale 1ns/1ns

module regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  exec_pkg::reg_addr_t addr_a,
  input  exec_pkg::reg_addr_t addr_b,
  input  exec_pkg::reg_addr_t addr_d,
  output exec_pkg::word_t     a,
  output exec_pkg::word_t     b,
  output exec_pkg::word_t     d,
  input  logic                wr_en,
  input  logic                wr_byte,
  input  exec_pkg::reg_addr_t wr_addr,
  input  exec_pkg::word_t     wr_data,
  input  logic                fl_en,
  input  exec_pkg::flags_t    fl_in,
  output exec_pkg::flags_t    flags
);
  import exec_pkg::*;

  word_t  regs [NUM_REGS];
  flags_t fl_q;

  // three read ports, old value until the edge.
  assign a     = regs[addr_a];
  assign b     = regs[addr_b];
  assign d     = regs[addr_d];  // store data and byte merge source.
  assign flags = fl_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;  // registers read as zero after reset.
      end
    end else if (wr_en) begin
      if (wr_byte) begin
        regs[wr_addr][7:0] <= wr_data[7:0];  // high byte kept.
      end else begin
        regs[wr_addr] <= wr_data;
      end
    end
  end

  // flag register, written on its own strobe.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fl_q <= '0;
    end else if (fl_en) begin
      fl_q <= fl_in;
    end
  end

endmodule

// File: verilog/alu.sv
// combinational alu; byte mode zeroes the result high byte, the address class ignores byteop.
`timescale 1ns/1ns

module alu (
  input  exec_pkg::word_t      a,
  input  exec_pkg::word_t      b,
  input  exec_pkg::alu_class_t cls,
  input  exec_pkg::alu_func_t  func,
  input  logic                 byteop,
  input  exec_pkg::flags_t     fl_in,
  output exec_pkg::word_t      result,
  output exec_pkg::flags_t     fl_out
);
  import exec_pkg::*;

  word_t           am;      // a trimmed to the lane.
  word_t           bm;
  logic            sub_op;  // sub and sbb.
  logic            cin;     // carry or borrow in.
  logic [WORD_W:0] sum;
  word_t           ares;
  logic            carry;
  logic            ovf;
  logic            upd;     // sf and zf follow the result.

  // sign bit of the active lane.
  function automatic logic msb(input word_t v, input logic bo);
    return bo ? v[7] : v[WORD_W-1];
  endfunction

  assign am     = byteop ? {8'h00, a[7:0]} : a;
  assign bm     = byteop ? {8'h00, b[7:0]} : b;
  assign sub_op = func[1];
  assign cin    = func[0] & fl_in[FLAG_CF];  // adc, sbb.
  assign sum    = sub_op ? {1'b0, am} - {1'b0, bm} - cin
                         : {1'b0, am} + {1'b0, bm} + cin;
  assign ares   = byteop ? {8'h00, sum[7:0]} : sum[WORD_W-1:0];
  assign carry  = byteop ? sum[8] : sum[WORD_W];  // borrow on sub.
  // overflow when the sign of a moves against the operand signs.
  assign ovf    = (msb(ares, byteop) != msb(am, byteop)) &&
                  (sub_op ? (msb(am, byteop) != msb(bm, byteop))
                          : (msb(am, byteop) == msb(bm, byteop)));

  always_comb begin
    result = a + b;  // address sum, full word.
    fl_out = fl_in;
    upd    = 1'b1;
    case (cls)
      CLS_ARITH: begin
        if (func == FN_PASSB) begin
          result = bm;
          upd    = 1'b0;  // every flag kept.
        end else begin
          result          = ares;
          fl_out[FLAG_CF] = carry;
          fl_out[FLAG_OF] = ovf;
        end
      end
      CLS_LOGIC: begin
        case (func)
          FN_AND:  result = am & bm;
          FN_OR:   result = am | bm;
          FN_XOR:  result = am ^ bm;
          default: result = '0;
        endcase
        fl_out[FLAG_CF] = 1'b0;
        fl_out[FLAG_OF] = 1'b0;
      end
      CLS_SHIFT: begin
        case (func)
          FN_SHL: begin
            result          = byteop ? {8'h00, am[6:0], 1'b0} : {am[WORD_W-2:0], 1'b0};
            fl_out[FLAG_CF] = msb(am, byteop);  // bit pushed out the top.
          end
          FN_SHR: begin
            result          = {1'b0, am[WORD_W-1:1]};  // high byte already zero in byte mode.
            fl_out[FLAG_CF] = am[0];
          end
          FN_SAR: begin
            result          = byteop ? {8'h00, am[7], am[7:1]} : {am[WORD_W-1], am[WORD_W-1:1]};
            fl_out[FLAG_CF] = am[0];
          end
          default: result = am;
        endcase
        fl_out[FLAG_OF] = 1'b0;
      end
      CLS_ADDR: upd = 1'b0;  // effective address only.
    endcase
    if (upd) begin
      fl_out[FLAG_SF] = msb(result, byteop);
      fl_out[FLAG_ZF] = (result == '0);
    end
  end

endmodule

// File: verilog/jmp_cond.sv
// condition test on the flags; cond[2:0] picks the test, cond[3] inverts it.
`timescale 1ns/1ns

module jmp_cond (
  input  exec_pkg::flags_t flags,
  input  exec_pkg::cond_t  cond,
  output logic             taken
);
  import exec_pkg::*;

  logic lt;    // signed less than.
  logic test;  // before inversion.

  assign lt = flags[FLAG_SF] ^ flags[FLAG_OF];

  always_comb begin
    case (cond[2:0])
      3'd0:    test = flags[FLAG_OF];                    // o.
      3'd1:    test = flags[FLAG_CF];                    // b, unsigned below.
      3'd2:    test = flags[FLAG_ZF];                    // z.
      3'd3:    test = flags[FLAG_SF];                    // s.
      3'd4:    test = flags[FLAG_CF] | flags[FLAG_ZF];   // be.
      3'd5:    test = lt;                                // l.
      3'd6:    test = lt | flags[FLAG_ZF];               // le.
      default: test = 1'b1;                              // always, never when inverted.
    endcase
  end

  assign taken = test ^ cond[3];

endmodule

// File: verilog/exec_stage.sv
// one uop per cycle, in order; register and flag reads see the previous uop's writes, no bypass.
`timescale 1ns/1ns

module exec_stage (
  input  logic                clk,
  input  logic                rst_n,
  issue_if.stage              s,
  input  logic                mem_block,
  output logic                wb_valid,
  output exec_pkg::reg_addr_t wb_addr,
  output exec_pkg::word_t     wb_data,
  output exec_pkg::flags_t    flags,
  output logic                mem_we,
  output exec_pkg::word_t     mem_addr,
  output exec_pkg::word_t     mem_data
);
  import exec_pkg::*;

  reg_addr_t  addr_a, addr_b, addr_d;
  alu_class_t cls;
  alu_func_t  func;
  cond_t      cond;
  logic       b_imm, byteop, wr, wrfl, wr_cnd, we;
  word_t      a, b, d;
  word_t      bus_b;    // second alu operand.
  word_t      result;
  word_t      new_d;    // full register value after the write.
  flags_t     fl_cur;   // flags before this uop.
  flags_t     fl_alu;
  logic       taken;
  logic       reg_we, fl_we, st_we;

  // field slicing.
  assign addr_a = s.uop[UOP_ADDR_A +: REG_AW];
  assign addr_b = s.uop[UOP_ADDR_B +: REG_AW];
  assign addr_d = s.uop[UOP_ADDR_D +: REG_AW];
  assign b_imm  = s.uop[UOP_B_IMM];
  assign cls    = s.uop[UOP_CLS +: 2];
  assign func   = s.uop[UOP_FUNC +: 3];
  assign byteop = s.uop[UOP_BYTEOP];
  assign wr     = s.uop[UOP_WR];
  assign wrfl   = s.uop[UOP_WRFL];
  assign wr_cnd = s.uop[UOP_WR_CND];
  assign cond   = s.uop[UOP_COND +: 4];
  assign we     = s.uop[UOP_WE];

  assign s.issue = s.valid & ~mem_block;  // back-pressure stalls the head.
  assign bus_b   = b_imm ? s.imm : b;
  assign reg_we  = s.issue & (wr | (wr_cnd & taken));
  assign fl_we   = s.issue & wrfl & (cls != CLS_ADDR);  // stores leave flags alone.
  assign st_we   = s.issue & we;
  assign new_d   = byteop ? {d[WORD_W-1:8], result[7:0]} : result;
  assign flags   = fl_cur;  // flag register is the registered output.

  regfile regfile0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr_a  (addr_a),
    .addr_b  (addr_b),
    .addr_d  (addr_d),
    .a       (a),
    .b       (b),
    .d       (d),
    .wr_en   (reg_we),
    .wr_byte (byteop),
    .wr_addr (addr_d),
    .wr_data (result),
    .fl_en   (fl_we),
    .fl_in   (fl_alu),
    .flags   (fl_cur)
  );

  alu alu0 (
    .a      (a),
    .b      (bus_b),
    .cls    (cls),
    .func   (func),
    .byteop (byteop),
    .fl_in  (fl_cur),
    .result (result),
    .fl_out (fl_alu)
  );

  jmp_cond jmp_cond0 (
    .flags (fl_cur),
    .cond  (cond),
    .taken (taken)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      mem_we   <= 1'b0;
    end else begin
      wb_valid <= reg_we;  // low while stalled.
      mem_we   <= st_we;
    end
  end

  // payload, valid only with its strobe.
  always_ff @(posedge clk) begin
    if (reg_we) begin
      wb_addr <= addr_d;
      wb_data <= new_d;
    end
    if (st_we) begin
      mem_addr <= result;  // address class sum.
      mem_data <= d;
    end
  end

endmodule

// File: verilog/exec_top.sv
// sender starts with QUEUE_DEPTH credits and may assert in_valid only while holding one.
`timescale 1ns/1ns

module exec_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  exec_pkg::uop_t      in_uop,
  input  exec_pkg::word_t     in_imm,
  output logic                credit_ret,
  input  logic                mem_block,
  output logic                wb_valid,
  output exec_pkg::reg_addr_t wb_addr,
  output exec_pkg::word_t     wb_data,
  output exec_pkg::flags_t    flags,
  output logic                mem_we,
  output exec_pkg::word_t     mem_addr,
  output exec_pkg::word_t     mem_data
);

  issue_if iq ();  // queue head to stage.

  uop_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_uop     (in_uop),
    .in_imm     (in_imm),
    .credit_ret (credit_ret),
    .q          (iq.queue)
  );

  exec_stage stage0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .s         (iq.stage),
    .mem_block (mem_block),
    .wb_valid  (wb_valid),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .flags     (flags),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data)
  );

endmodule

// File: verification/exec_assert.sv
// credit, stall and return checks on exec_top; sender credits are rebuilt here from the ports.
`timescale 1ns/1ns

module exec_assert #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic credit_ret,
  input logic mem_block,
  input logic issue,
  input logic wb_valid,
  input logic mem_we
);

  int credits;  // sender side view.
  int pending;  // issued, credit not yet back.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= QUEUE_DEPTH;
      pending <= 0;
    end else begin
      credits <= credits - int'(in_valid) + int'(credit_ret);
      pending <= pending + int'(issue) - int'(credit_ret);
    end
  end

  // a credit arriving this cycle may already be spent.
  push_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (credits + int'(credit_ret)) > 0)
    else $error("push without a credit");

  stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_block && !issue) |=> (!wb_valid && !mem_we))
    else $error("output strobe after a stalled cycle");

  credit_once: assert property (@(posedge clk) disable iff (!rst_n)
    credit_ret |-> pending > 0)
    else $error("credit returned without an issued entry");

endmodule

bind exec_top exec_assert #(
  .QUEUE_DEPTH (QUEUE_DEPTH)
) assert0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .credit_ret (credit_ret),
  .mem_block  (mem_block),
  .issue      (iq.issue),
  .wb_valid   (wb_valid),
  .mem_we     (mem_we)
);

// File: verification/tb_exec.sv
// cases are read from verification/exec_cases.txt, so run from the project root; max 64 cases.
`timescale 1ns/1ns

module tb_exec;
  import exec_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int MAX_CASES   = 64;

  logic clk = 1'b0;
  logic rst_n, in_valid, credit_ret, mem_block, wb_valid, mem_we;
  uop_t in_uop;
  word_t in_imm, wb_data, mem_addr, mem_data;
  reg_addr_t wb_addr;
  flags_t flags;

  string case_name [MAX_CASES];
  logic [31:0] c_uop [MAX_CASES];
  logic [31:0] c_imm [MAX_CASES];
  logic [31:0] c_wbv [MAX_CASES];
  logic [31:0] c_wba [MAX_CASES];
  logic [31:0] c_wbd [MAX_CASES];
  logic [31:0] c_fl [MAX_CASES];
  logic [31:0] c_st [MAX_CASES];
  logic [31:0] c_sta [MAX_CASES];
  logic [31:0] c_std [MAX_CASES];
  int ev_case [MAX_CASES];  // cases that show an output, in order.
  int n_cases = 0;
  int n_ev = 0;

  exec_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (.*);

  always #2 clk = ~clk;  // 4 ns period.

  task automatic report_fail();
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("error %s %s expected %h actual %h", name, what, exp, act);
      report_fail();
    end
  endtask

  task automatic load_cases();
    int fd;
    string line;
    fd = $fopen("verification/exec_cases.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open the cases file");
      report_fail();
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 3 || line[0] == "#") continue;
      void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h", case_name[n_cases],
        c_uop[n_cases], c_imm[n_cases], c_wbv[n_cases], c_wba[n_cases], c_wbd[n_cases],
        c_fl[n_cases], c_st[n_cases], c_sta[n_cases], c_std[n_cases]));
      if (c_wbv[n_cases][0] || c_st[n_cases][0]) begin
        ev_case[n_ev] = n_cases;  // silent cases leave no event.
        n_ev++;
      end
      n_cases++;
    end
    $fclose(fd);
  endtask

  initial begin
    int credits, sent, seen, cycles, limit, k;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_uop = '0;
    in_imm = '0;
    mem_block = 1'b0;
    void'($urandom(85));  // one seed for the whole run.
    load_cases();
    credits = QUEUE_DEPTH;
    sent = 0;
    seen = 0;
    cycles = 0;
    limit = 20 * n_cases + 100;  // generous for random stalls.
    repeat (10) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    while (!(sent == n_cases && seen == n_ev && credits == QUEUE_DEPTH)) begin
      @(negedge clk);
      cycles++;
      assert (cycles < limit) else begin
        $display("timeout after %0d cycles, %0d of %0d outputs seen", cycles, seen, n_ev);
        report_fail();
      end
      if (sent == 0) begin
        assert (!wb_valid && !mem_we && !credit_ret) else begin
          $display("output strobe or credit before the first microinstruction was sent");
          report_fail();
        end
      end
      if (credit_ret) credits++;
      assert (credits <= QUEUE_DEPTH) else begin
        $display("more credits returned than entries sent");
        report_fail();
      end
      if (wb_valid || mem_we) begin
        assert (seen < n_ev) else begin
          $display("output seen with no case left to match it");
          report_fail();
        end
        k = ev_case[seen];
        check_val(case_name[k], "wb_valid", c_wbv[k], 32'(wb_valid));
        if (c_wbv[k][0]) begin
          check_val(case_name[k], "wb_addr", c_wba[k], 32'(wb_addr));
          check_val(case_name[k], "wb_data", c_wbd[k], 32'(wb_data));
        end
        check_val(case_name[k], "flags", c_fl[k], 32'(flags));
        check_val(case_name[k], "mem_we", c_st[k], 32'(mem_we));
        if (c_st[k][0]) begin
          check_val(case_name[k], "mem_addr", c_sta[k], 32'(mem_addr));
          check_val(case_name[k], "mem_data", c_std[k], 32'(mem_data));
        end
        seen++;
      end
      mem_block = ($urandom % 4) == 0;  // stall about one cycle in four.
      if (sent < n_cases && credits > 0 && ($urandom % 3) != 0) begin
        in_valid = 1'b1;
        in_uop = c_uop[sent];
        in_imm = c_imm[sent][15:0];
        credits--;
        sent++;
      end else begin
        in_valid = 1'b0;
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: verification/exec_cases.txt
# name uop imm wb_valid wb_addr wb_data flags(of sf zf cf) store st_addr st_data
# all values hex; silent cases have wb_valid and store both 0
z_add    30040  0000 1 1 0000 2 0 0000 0000
z_add_nf 100bf  0000 1 2 0000 2 0 0000 0000
ld_r1    14240  7fff 1 1 7fff 2 0 0000 0000
ld_r2    14280  0001 1 2 0001 2 0 0000 0000
ld_r3    142c0  ffff 1 3 ffff 2 0 0000 0000
add_ovf  30111  0000 1 4 8000 c 0 0000 0000
add_cy   30153  0000 1 5 0000 3 0 0000 0000
adc      31192  0000 1 6 0003 0 0 0000 0000
sub_brw  321f2  0000 1 7 fffe 5 0 0000 0000
sbb_ovf  33194  0000 1 6 7ffe 8 0 0000 0000
and_imm  30743  0f0f 1 5 0f0f 0 0 0000 0000
or_byte  397c7  0001 1 7 ffff 4 0 0000 0000
xor_zero 3256d  0000 1 5 0000 2 0 0000 0000
xor_byte 3a641  00ff 1 1 7f00 2 0 0000 0000
shl_cy   30884  0000 1 2 0000 3 0 0000 0000
shr      31887  0000 1 2 7fff 1 0 0000 0000
sar      32984  0000 1 6 c000 4 0 0000 0000
shl_byte 388c3  0000 1 3 fffe 5 0 0000 0000
sar_byte 3a8c3  0000 1 3 ffff 4 0 0000 0000
cnd_o    44340  0100 0 0 0000 4 0 0000 0000
cnd_b    c4340  0101 0 0 0000 4 0 0000 0000
cnd_z    144340 0102 0 0 0000 4 0 0000 0000
cnd_s    1c4340 0103 1 5 0103 4 0 0000 0000
cnd_be   244340 0104 0 0 0000 4 0 0000 0000
cnd_l    2c4340 0105 1 5 0105 4 0 0000 0000
cnd_le   344340 0106 1 5 0106 4 0 0000 0000
cnd_al   3c4340 0107 1 5 0107 4 0 0000 0000
cnd_no   444340 0108 1 5 0108 4 0 0000 0000
cnd_nb   4c4340 0109 1 5 0109 4 0 0000 0000
cnd_nz   544340 010a 1 5 010a 4 0 0000 0000
cnd_ns   5c4340 010b 0 0 0000 4 0 0000 0000
cnd_nbe  644340 010c 1 5 010c 4 0 0000 0000
cnd_nl   6c4340 010d 0 0 0000 4 0 0000 0000
cnd_nle  744340 010e 0 0 0000 4 0 0000 0000
cnd_nev  7c4340 010f 0 0 0000 4 0 0000 0000
st_imm   820fc4 0010 0 0 0000 4 1 8010 ffff
st_reg   820d5a 0000 0 0 0000 4 1 7ffe 010c
add_end  30025  0000 1 0 810c 4 0 0000 0000

// File: filelist.f
verilog/exec_pkg.sv
verilog/issue_if.sv
verilog/uop_queue.sv
verilog/regfile.sv
verilog/alu.sv
verilog/jmp_cond.sv
verilog/exec_stage.sv
verilog/exec_top.sv
verification/exec_assert.sv
verification/tb_exec.sv

// File: run.sh
#!/bin/sh
# run from the project root; exit status is the simulation result.
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_exec -o tb_exec \
  && ./obj_dir/tb_exec \
  || exit 1
